//--- hw/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // direct mapped, 16 sets of 2 words
    localparam int WORD_BITS     = 32;
    localparam int N_SETS        = 16;
    localparam int BLOCK_WORDS   = 2;
    localparam int BYTE_BITS     = 2;                  // byte offset within a word
    localparam int SET_BITS      = $clog2(N_SETS);
    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS      = WORD_BITS - SET_BITS - WORD_SEL_BITS - BYTE_BITS;

    // data and address word
    typedef logic [WORD_BITS-1:0]     word_t;

    // address fields
    typedef logic [SET_BITS-1:0]      set_idx_t;
    typedef logic [WORD_SEL_BITS-1:0] word_sel_t;
    typedef logic [TAG_BITS-1:0]      tag_t;

    // one enable per byte lane
    typedef logic [3:0]               byte_en_t;

endpackage

`default_nettype wire

//--- hw/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

    // controller states
    typedef enum logic [2:0] {
        INIT,           // invalidate every set after reset
        READY,          // serve hits, detect misses
        WRITE_BACK,     // evict dirty victim
        REFILL,         // fetch block from memory
        FLUSH           // write back and clear all sets
    } cache_state_t;

    // line store write commands, one per cycle
    typedef enum logic [2:0] {
        ST_NONE,
        ST_CLEAR_LINE,  // valid, dirty, tag to zero
        ST_FILL_WORD,   // refill word, line invalid meanwhile
        ST_FILL_DONE,   // last refill word plus tag, line valid and clean
        ST_CPU_WRITE,   // byte merged store, line dirty
        ST_MARK_CLEAN   // victim written back
    } store_cmd_t;

endpackage

`default_nettype wire

//--- hw/cache_tag_check.sv
`default_nettype none
`timescale 1ns/1ps

module cache_tag_check (
    input  cache_geom_pkg::word_t     addr,
    input  cache_geom_pkg::tag_t      line_tag,
    input  logic                      line_valid,
    output cache_geom_pkg::set_idx_t  req_set,
    output cache_geom_pkg::word_sel_t req_word,
    output cache_geom_pkg::tag_t      req_tag,
    output logic                      hit
);
    import cache_geom_pkg::*;

    // address layout is tag | set | word | byte
    assign req_tag  = addr[WORD_BITS-1 -: TAG_BITS];
    assign req_set  = addr[BYTE_BITS+WORD_SEL_BITS +: SET_BITS];
    assign req_word = addr[BYTE_BITS +: WORD_SEL_BITS];

    // byte offset plays no part in lookup
    assign hit = line_valid && (line_tag == req_tag);

endmodule

`default_nettype wire

//--- hw/cache_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       ren,
    input  logic                       wen,
    input  logic                       flush,
    input  logic                       hit,
    input  cache_geom_pkg::set_idx_t   req_set,
    input  cache_geom_pkg::tag_t       req_tag,
    input  logic                       line_valid,
    input  logic                       line_dirty,
    input  cache_geom_pkg::tag_t       line_tag,
    input  logic                       mem_busy,
    output logic                       busy,
    output logic                       flush_done,
    output logic                       mem_ren,
    output logic                       mem_wen,
    output cache_geom_pkg::word_t      mem_addr,
    output cache_geom_pkg::set_idx_t   store_set,
    output cache_geom_pkg::word_sel_t  store_word,
    output cache_ctrl_pkg::store_cmd_t store_cmd,
    output cache_geom_pkg::tag_t       fill_tag
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    cache_state_t state, next_state;
    word_sel_t    word_cnt, next_word_cnt;      // refill and eviction word
    set_idx_t     walk_set, next_walk_set;      // INIT and FLUSH walk
    word_sel_t    walk_word, next_walk_word;
    logic         flush_req, next_flush_req;    // flush seen outside READY
    logic         access;
    logic         flush_pend;
    logic         word_last;
    logic         walk_last_word;
    logic         walk_last_set;
    logic         walk_step;                    // current set finished

    assign access         = ren || wen;
    assign flush_pend     = flush || flush_req;
    assign word_last      = (word_cnt == word_sel_t'(BLOCK_WORDS - 1));
    assign walk_last_word = (walk_word == word_sel_t'(BLOCK_WORDS - 1));
    assign walk_last_set  = (walk_set == set_idx_t'(N_SETS - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= INIT;
            word_cnt  <= '0;
            walk_set  <= '0;
            walk_word <= '0;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            word_cnt  <= next_word_cnt;
            walk_set  <= next_walk_set;
            walk_word <= next_walk_word;
            flush_req <= next_flush_req;
        end
    end

    always_comb begin
        next_state     = state;
        next_word_cnt  = word_cnt;
        next_walk_set  = walk_set;
        next_walk_word = walk_word;
        next_flush_req = flush_req || flush;
        busy           = 1'b1;
        flush_done     = 1'b0;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        mem_addr       = {req_tag, req_set, word_cnt, {BYTE_BITS{1'b0}}};   // refill address
        store_cmd      = ST_NONE;
        walk_step      = 1'b0;

        case (state)
            INIT: begin
                store_cmd     = ST_CLEAR_LINE;
                next_walk_set = walk_set + 1'b1;
                if (walk_last_set) begin
                    next_state = READY;
                end
            end
            READY: begin
                // flush wins over any pending access
                if (flush_pend) begin
                    next_state     = FLUSH;
                    next_flush_req = 1'b0;
                end else if (access && hit) begin
                    busy = 1'b0;
                    if (wen) begin
                        store_cmd = ST_CPU_WRITE;
                    end
                end else if (access) begin
                    next_state = (line_valid && line_dirty) ? WRITE_BACK : REFILL;
                end
            end
            WRITE_BACK: begin
                mem_wen  = 1'b1;
                mem_addr = {line_tag, req_set, word_cnt, {BYTE_BITS{1'b0}}};  // victim address
                if (!mem_busy) begin
                    if (word_last) begin
                        store_cmd     = ST_MARK_CLEAN;
                        next_word_cnt = '0;
                        next_state    = REFILL;
                    end else begin
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end
            REFILL: begin
                mem_ren = 1'b1;
                if (!mem_busy) begin
                    if (word_last) begin
                        store_cmd     = ST_FILL_DONE;
                        next_word_cnt = '0;
                        next_state    = READY;   // access then completes as a hit
                    end else begin
                        store_cmd     = ST_FILL_WORD;
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end
            FLUSH: begin
                if (line_valid && line_dirty) begin
                    mem_wen  = 1'b1;
                    mem_addr = {line_tag, walk_set, walk_word, {BYTE_BITS{1'b0}}};
                    if (!mem_busy) begin
                        if (walk_last_word) begin
                            store_cmd      = ST_CLEAR_LINE;
                            next_walk_word = '0;
                            walk_step      = 1'b1;
                        end else begin
                            next_walk_word = walk_word + 1'b1;
                        end
                    end
                end else begin
                    store_cmd = ST_CLEAR_LINE;   // clean or empty, just drop it
                    walk_step = 1'b1;
                end
                if (walk_step) begin
                    next_walk_set = walk_set + 1'b1;
                    if (walk_last_set) begin
                        flush_done = 1'b1;
                        next_state = READY;
                    end
                end
            end
            default: next_state = INIT;
        endcase
    end

    // walk counter indexes the store during INIT and FLUSH
    assign store_set  = (state == INIT || state == FLUSH) ? walk_set : req_set;
    assign store_word = (state == FLUSH) ? walk_word : word_cnt;
    assign fill_tag   = req_tag;

    a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen high together");

    a_busy_ready: assert property (@(posedge CLK) disable iff (!nRST)
        !busy |-> state == READY)
        else $error("busy low outside READY");

    a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
        else $error("flush_done longer than one cycle");

endmodule

`default_nettype wire

//--- hw/cache_line_store.sv
`default_nettype none
`timescale 1ns/1ps

module cache_line_store (
    input  logic                       CLK,
    input  logic                       nRST,
    input  cache_geom_pkg::set_idx_t   store_set,
    input  cache_geom_pkg::word_sel_t  store_word,
    input  cache_ctrl_pkg::store_cmd_t store_cmd,
    input  cache_geom_pkg::tag_t       fill_tag,
    input  cache_geom_pkg::word_t      mem_rdata,
    input  cache_geom_pkg::word_t      wdata,
    input  cache_geom_pkg::byte_en_t   byte_en,
    input  cache_geom_pkg::word_sel_t  req_word,
    output logic                       line_valid,
    output logic                       line_dirty,
    output cache_geom_pkg::tag_t       line_tag,
    output cache_geom_pkg::word_t      read_word,
    output cache_geom_pkg::word_t      evict_word
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    logic [N_SETS-1:0] valid_q;
    logic [N_SETS-1:0] dirty_q;
    tag_t              tag_q  [N_SETS];
    word_t             data_q [N_SETS][BLOCK_WORDS];
    word_t             merged;      // core store folded into old word
    logic              be_legal;

    // combinational reads at the selected set
    assign line_valid = valid_q[store_set];
    assign line_dirty = dirty_q[store_set];
    assign line_tag   = tag_q[store_set];
    assign read_word  = data_q[store_set][req_word];
    assign evict_word = data_q[store_set][store_word];

    always_comb begin
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            merged[8*i +: 8] = byte_en[i] ? wdata[8*i +: 8] : read_word[8*i +: 8];
        end
    end

    // line status bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (store_cmd)
                ST_CLEAR_LINE, ST_MARK_CLEAN: begin
                    valid_q[store_set] <= 1'b0;
                    dirty_q[store_set] <= 1'b0;
                end
                ST_FILL_WORD: valid_q[store_set] <= 1'b0;   // half filled
                ST_FILL_DONE: begin
                    valid_q[store_set] <= 1'b1;
                    dirty_q[store_set] <= 1'b0;
                end
                ST_CPU_WRITE: dirty_q[store_set] <= 1'b1;
                default: ;
            endcase
        end
    end

    // tags and data
    always_ff @(posedge CLK) begin
        case (store_cmd)
            ST_CLEAR_LINE: tag_q[store_set] <= '0;
            ST_FILL_WORD:  data_q[store_set][store_word] <= mem_rdata;
            ST_FILL_DONE: begin
                data_q[store_set][store_word] <= mem_rdata;
                tag_q[store_set]              <= fill_tag;
            end
            ST_CPU_WRITE:  data_q[store_set][req_word] <= merged;
            default: ;
        endcase
    end

    // byte, aligned half or full word only
    assign be_legal = byte_en inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                      4'b0011, 4'b1100, 4'b1111};

    a_byte_en: assert property (@(posedge CLK) disable iff (!nRST)
        store_cmd == ST_CPU_WRITE |-> be_legal)
        else $error("illegal byte_en %b on write hit", byte_en);

endmodule

`default_nettype wire

//--- hw/l1_cache.sv
`default_nettype none
`timescale 1ns/1ps

module l1_cache (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     ren,
    input  logic                     wen,
    input  logic                     flush,
    input  cache_geom_pkg::word_t    addr,
    input  cache_geom_pkg::word_t    wdata,
    input  cache_geom_pkg::byte_en_t byte_en,
    output logic                     busy,
    output logic                     flush_done,
    output cache_geom_pkg::word_t    rdata,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output cache_geom_pkg::word_t    mem_addr,
    output cache_geom_pkg::word_t    mem_wdata,
    input  cache_geom_pkg::word_t    mem_rdata,
    input  logic                     mem_busy
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    set_idx_t   req_set;
    word_sel_t  req_word;
    tag_t       req_tag;
    logic       hit;
    set_idx_t   store_set;
    word_sel_t  store_word;
    store_cmd_t store_cmd;
    tag_t       fill_tag;
    logic       line_valid;
    logic       line_dirty;
    tag_t       line_tag;

    cache_tag_check u_tag_check (
        .addr(addr), .line_tag(line_tag), .line_valid(line_valid),
        .req_set(req_set), .req_word(req_word), .req_tag(req_tag), .hit(hit)
    );

    cache_ctrl u_ctrl (
        .CLK(CLK), .nRST(nRST), .ren(ren), .wen(wen), .flush(flush),
        .hit(hit), .req_set(req_set), .req_tag(req_tag),
        .line_valid(line_valid), .line_dirty(line_dirty), .line_tag(line_tag),
        .mem_busy(mem_busy), .busy(busy), .flush_done(flush_done),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .store_set(store_set), .store_word(store_word),
        .store_cmd(store_cmd), .fill_tag(fill_tag)
    );

    cache_line_store u_line_store (
        .CLK(CLK), .nRST(nRST), .store_set(store_set), .store_word(store_word),
        .store_cmd(store_cmd), .fill_tag(fill_tag), .mem_rdata(mem_rdata),
        .wdata(wdata), .byte_en(byte_en), .req_word(req_word),
        .line_valid(line_valid), .line_dirty(line_dirty), .line_tag(line_tag),
        .read_word(rdata), .evict_word(mem_wdata)
    );

    // a completed access always finds its block in the store
    a_done_is_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (ren || wen) && !busy |-> hit)
        else $error("access completed without a hit");

endmodule

`default_nettype wire

//--- verif/mem_model.sv
`default_nettype none
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] FILL_XOR = 32'h5A3C_96E1
) (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  mem_ren,
    input  logic                  mem_wen,
    input  cache_geom_pkg::word_t mem_addr,
    input  cache_geom_pkg::word_t mem_wdata,
    output cache_geom_pkg::word_t mem_rdata,
    output logic                  mem_busy
);
    import cache_geom_pkg::*;

    localparam int DEPTH = 4096;                // 16 KiB window, wraps above

    word_t      store [DEPTH];
    integer     seed = 32'h3527;
    logic       armed;                          // stall drawn for current word
    logic [1:0] stall_left;
    logic       strobe;

    assign strobe    = mem_ren || mem_wen;
    assign mem_busy  = strobe && (!armed || stall_left != 2'd0);   // 1 to 3 busy cycles
    assign mem_rdata = store[mem_addr[13:2]];

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            armed      <= 1'b0;
            stall_left <= 2'd0;
            for (int i = 0; i < DEPTH; i++) begin
                store[i] <= (word_t'(i) << 2) ^ FILL_XOR;   // preload from full address
            end
        end else if (strobe) begin
            if (!armed) begin
                armed      <= 1'b1;
                stall_left <= 2'($unsigned($random(seed)) % 3);
            end else if (stall_left != 2'd0) begin
                stall_left <= stall_left - 2'd1;
            end else begin
                if (mem_wen) begin
                    store[mem_addr[13:2]] <= mem_wdata;
                end
                armed <= 1'b0;                  // word accepted
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/l1_cache_tb.sv
`default_nettype none
`timescale 1ns/1ps

module l1_cache_tb;
    import cache_geom_pkg::*;

    localparam word_t FILL_XOR  = 32'h5A3C_96E1;
    localparam int    MEM_WORDS = 4096;
    localparam int    OP_READ   = 0;
    localparam int    OP_WRITE  = 1;
    localparam int    OP_FLUSH  = 2;

    typedef struct {
        int       op;
        word_t    addr;
        word_t    data;
        byte_en_t be;
        int       id;
        bit       hit;      // no memory traffic allowed
    } row_t;

    logic     CLK, nRST, ren, wen, flush, busy, flush_done;
    logic     mem_ren, mem_wen, mem_busy;
    word_t    addr, wdata, rdata, mem_addr, mem_wdata, mem_rdata;
    byte_en_t byte_en;

    row_t  rows[$];
    word_t ref_mem [MEM_WORDS];
    int    written[$];
    int    errors = 0;
    int    cycles = 0;
    int    limit = 0;
    int    xfers = 0;
    int    done_pulses = 0;
    int    flushes = 0;

    // every legal lane pattern
    byte_en_t byte_en_list [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                   4'b0011, 4'b1100, 4'b1111};

    l1_cache i_dut (
        .CLK(CLK), .nRST(nRST), .ren(ren), .wen(wen), .flush(flush),
        .addr(addr), .wdata(wdata), .byte_en(byte_en), .busy(busy),
        .flush_done(flush_done), .rdata(rdata), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_busy(mem_busy)
    );

    mem_model #(.FILL_XOR(FILL_XOR)) u_mem (
        .CLK(CLK), .nRST(nRST), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_busy(mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // bus and flush monitors, plus the run limit
    always @(posedge CLK) begin
        cycles++;
        if ((mem_ren || mem_wen) && !mem_busy) xfers++;
        if (flush_done) done_pulses++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the cache never finished", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
        word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};   // lane enables as bit mask
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic add_row(int op, word_t a, word_t d, byte_en_t be, int id, bit hit);
        row_t r;
        r = '{op, a, d, be, id, hit};
        rows.push_back(r);
    endtask

    task automatic run_access(input row_t r, input int n);
        int    a;
        int    x0;
        word_t exp;
        a  = int'(r.addr[13:2]);
        x0 = xfers;
        ren = (r.op == OP_READ);
        wen = (r.op == OP_WRITE);
        addr = r.addr;
        wdata = r.data;
        byte_en = r.be;
        #1;
        while (busy) begin
            @(negedge CLK);
            #1;
        end
        if (r.op == OP_READ) begin
            exp = ref_mem[a];
            assert (rdata == exp)
                else begin
                    $display("** Error at %0t: read %h got %h expected %h",
                             $time, r.addr, rdata, exp);
                    errors++;
                end
        end else begin
            ref_mem[a] = merge_bytes(ref_mem[a], r.data, r.be);
            written.push_back(a);
        end
        @(posedge CLK);
        @(negedge CLK);
        ren = 1'b0;
        wen = 1'b0;
        if (r.hit) begin
            assert (xfers == x0)
                else begin
                    $display("memory was accessed on an expected hit at %h", r.addr);
                    errors++;
                end
        end
        $display("test %0d row %0d: %s %h done, errors so far %0d",
                 r.id, n, (r.op == OP_READ) ? "read" : "write", r.addr, errors);
    endtask

    task automatic run_flush(input row_t r, input int n);
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        #1;
        while (!flush_done) begin
            @(negedge CLK);
            #1;
        end
        repeat (2) @(posedge CLK);   // one more edge catches a stretched pulse
        @(negedge CLK);
        flushes++;
        assert (done_pulses == flushes)
            else begin
                $display("flush_done pulsed %0d times for %0d flushes", done_pulses, flushes);
                errors++;
            end
        foreach (written[k]) begin
            assert (u_mem.store[written[k]] == ref_mem[written[k]])
                else begin
                    $display("** Error at %0t: memory word %0d is %h expected %h", $time,
                             written[k], u_mem.store[written[k]], ref_mem[written[k]]);
                    errors++;
                end
        end
        $display("test %0d row %0d: flush done, errors so far %0d", r.id, n, errors);
    endtask

    initial begin
        nRST = 1'b0;
        ren = 1'b0;
        wen = 1'b0;
        flush = 1'b0;
        addr = '0;
        wdata = '0;
        byte_en = '0;
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = (word_t'(i) << 2) ^ FILL_XOR;

        add_row(OP_READ, 32'h1000, 0, 4'hf, 1, 0);          // cold miss
        add_row(OP_READ, 32'h1004, 0, 4'hf, 2, 1);
        add_row(OP_READ, 32'h1000, 0, 4'hf, 2, 1);
        foreach (byte_en_list[k]) begin
            add_row(OP_WRITE, 32'h1000 | (k[0] << 2), 32'hC0DE_0000 + k * 32'h1111_0101,
                    byte_en_list[k], 3, 1);
            add_row(OP_READ, 32'h1000 | (k[0] << 2), 0, 4'hf, 3, 1);
        end
        add_row(OP_WRITE, 32'h2008, 32'hDEAD_BEEF, 4'hf, 4, 0);
        add_row(OP_READ, 32'h3008, 0, 4'hf, 4, 0);          // same set, evicts
        add_row(OP_READ, 32'h2008, 0, 4'hf, 4, 0);
        add_row(OP_WRITE, 32'h4010, 32'h1234_5678, 4'hf, 5, 0);
        add_row(OP_WRITE, 32'h4018, 32'h8765_4321, 4'h3, 5, 0);
        add_row(OP_WRITE, 32'h5020, 32'hA5A5_5A5A, 4'hc, 5, 0);
        add_row(OP_FLUSH, 0, 0, 4'h0, 5, 0);
        add_row(OP_READ, 32'h4010, 0, 4'hf, 5, 0);
        add_row(OP_READ, 32'h4018, 0, 4'hf, 5, 0);
        add_row(OP_READ, 32'h5020, 0, 4'hf, 5, 0);
        limit = 16 + rows.size() * 4 * 4 + 32 * 4 + 200;

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        foreach (rows[n]) begin
            if (rows[n].op == OP_FLUSH) run_flush(rows[n], n);
            else run_access(rows[n], n);
        end

        $display("%0d rows run, %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hw/cache_geom_pkg.sv
hw/cache_ctrl_pkg.sv
hw/cache_tag_check.sv
hw/cache_ctrl.sv
hw/cache_line_store.sv
hw/l1_cache.sv
verif/mem_model.sv
verif/l1_cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module l1_cache_tb -o sim_l1_cache \
    && ./obj_dir/sim_l1_cache | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0
